// ==== verilog/noc_settings.svh ====
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// ========================================
// Switch dimensions
// ========================================

`define NOC_FLIT_WIDTH 32      // Width of one flit in bits.
`define NOC_CHANNELS   3       // Number of input channels.
`define NOC_OUTPUTS    2       // Number of output ports.

// ========================================
// Header flit layout
// ========================================

// The destination sits in the top bits of the header flit.
`define NOC_DEST_WIDTH 1       // One bit selects between the two outputs.

`endif

// ==== verilog/noc_pkg.sv ====
`default_nettype none

`include "noc_settings.svh"

package noc_pkg;

   // ========================================
   // Data path types
   // ========================================

   typedef logic [`NOC_FLIT_WIDTH-1:0] flit_t;     // One flit of a worm.
   typedef logic [`NOC_CHANNELS-1:0]   chan_vec_t; // One bit per input channel.
   typedef logic [`NOC_OUTPUTS-1:0]    out_vec_t;  // One bit per output port.
   typedef logic [`NOC_DEST_WIDTH-1:0] dest_t;     // Output index from the header.

   // Lock state of an output mux.
   typedef enum logic {
      idle,                                         // Free to arbitrate.
      worm                                          // Locked onto one worm.
   } mux_state_t;

endpackage

`default_nettype wire

// ==== verilog/arb_rr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module arb_rr
   import noc_pkg::*;
#(
   parameter int n = `NOC_CHANNELS                 // Number of requesters.
) (
   input  chan_vec_t req,                          // Request per channel.
   input  chan_vec_t gnt,                          // Grant of the last arbitration.
   input  logic      en,                           // Arbitration enable.
   output chan_vec_t nxt_gnt                       // One-hot grant for this cycle.
);

   // ========================================
   // Cyclic search
   // ========================================

   // The search walks the offsets from the farthest to the nearest, so the
   // nearest requester after the previous grant is the one that stays.
   // The previous holder itself has offset n and thus the lowest priority.
   always_comb begin
      nxt_gnt = gnt;                               // Hold the grant by default.
      if (en && (|req)) begin
         for (int p = 0; p < n; p++) begin
            if (gnt[p]) begin                      // Found the previous holder.
               for (int k = n; k >= 1; k--) begin
                  if (req[(p + k) % n]) begin
                     nxt_gnt = '0;
                     nxt_gnt[(p + k) % n] = 1'b1;  // Nearest requester wins.
                  end
               end
            end
         end
      end
   end

   // An enabled arbitration with requests must hand out exactly one grant to a requester.
   always_comb begin
      if (en && (|req)) begin
         assert ($onehot(nxt_gnt) && (|(nxt_gnt & req)))
         else $error("arb_rr: nxt_gnt %h is not a one-hot grant of req %h", nxt_gnt, req);
      end
   end

endmodule

`default_nettype wire

// ==== verilog/noc_route_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module noc_route_decode
   import noc_pkg::*;
(
   input  logic     clk,
   input  logic     rst,

   // Input channel from the source.
   input  flit_t    flit,                          // Current flit.
   input  logic     last,                          // Flit closes the worm.
   input  logic     valid,                         // Flit is offered.
   output logic     ready,                         // Flit is taken this cycle.

   // Request side towards the output muxes.
   output out_vec_t req_valid,                     // Valid steered to one output.
   input  out_vec_t grant_ready                    // Ready returned by each output.
);

   logic  in_worm;                                 // Set between header and last flit.
   dest_t dest_q;                                  // Destination of the current worm.
   dest_t dest;                                    // Destination in use this cycle.
   logic  xfer;                                    // A flit moves this cycle.

   // ========================================
   // Destination select
   // ========================================

   // Headers carry the route in the top bits; body flits reuse the latched one.
   assign dest = in_worm ? dest_q : flit[`NOC_FLIT_WIDTH-1 -: `NOC_DEST_WIDTH];

   assign xfer = valid && ready;                   // Handshake at the input.

   // Only the chosen output sees this input as valid.
   always_comb begin
      req_valid = '0;
      req_valid[dest] = valid;
   end

   assign ready = grant_ready[dest];               // Ready comes from the same output.

   // ========================================
   // Worm tracking
   // ========================================

   always_ff @(posedge clk) begin
      if (rst) begin
         in_worm <= 1'b0;                          // Start at a worm boundary.
      end else if (xfer) begin
         in_worm <= ~last;                         // The last flit ends the worm.
      end
   end

   // The route is captured when the header flit is accepted.
   always_ff @(posedge clk) begin
      if (xfer && !in_worm) begin
         dest_q <= dest;
      end
   end

   // Once a non-last flit has moved, the worm keeps the same route next cycle.
   assert property (@(posedge clk) disable iff (rst)
      (xfer && !last) |=> (dest == $past(dest)))
   else $error("noc_route_decode: destination changed inside a worm");

endmodule

`default_nettype wire

// ==== verilog/noc_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module noc_mux
   import noc_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst,

   // One request port per input channel.
   input  flit_t [`NOC_CHANNELS-1:0] in_flit,      // Flit of every channel.
   input  chan_vec_t                in_last,       // Last flag of every channel.
   input  chan_vec_t                in_valid,      // Requests for this output.
   output chan_vec_t                in_ready,      // Grant with handshake.

   // Output port towards the sink.
   output flit_t                    out_flit,
   output logic                     out_last,
   output logic                     out_valid,
   input  logic                     out_ready
);

   mux_state_t state;                              // Lock state.
   mux_state_t nxt_state;
   chan_vec_t  active;                             // Last granted channel.
   chan_vec_t  select;                             // Channel routed to the output.
   chan_vec_t  req_masked;                         // Requests seen by the arbiter.

   // ========================================
   // Arbitration
   // ========================================

   // No new arbitration while a worm holds the lock.
   assign req_masked = (state == idle) ? in_valid : '0;

   // A stalled sink disables the arbiter, which then passes the previous grant through.
   arb_rr #(
      .n       (`NOC_CHANNELS)
   ) u_arb (
      .req     (req_masked),
      .gnt     (active),
      .en      (out_ready),
      .nxt_gnt (select)
   );

   // ========================================
   // Data path
   // ========================================

   always_comb begin
      out_flit = '0;
      out_last = 1'b0;
      for (int c = 0; c < `NOC_CHANNELS; c++) begin
         if (select[c]) begin
            out_flit = in_flit[c];                 // Selected flit goes straight out.
            out_last = in_last[c];
         end
      end
   end

   assign out_valid = |(in_valid & select);        // Valid only from the selected channel.
   assign in_ready  = out_ready ? (in_valid & select) : '0; // Ready needs the sink.

   // ========================================
   // Lock control
   // ========================================

   // Any transfer without last locks the mux and a last flit frees it.
   always_comb begin
      nxt_state = state;
      if (|in_ready) begin
         nxt_state = out_last ? idle : worm;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state  <= idle;
         active <= chan_vec_t'(1);                 // Channel 0 held the last grant.
      end else begin
         state <= nxt_state;
         if (|in_ready) begin
            active <= in_ready;                    // Priority moves only on a transfer.
         end
      end
   end

   // At most one channel is served per cycle.
   assert property (@(posedge clk) disable iff (rst) $onehot0(in_ready))
   else $error("noc_mux: in_ready %h is not one-hot", in_ready);

   // A stalled sink freezes both the lock and the round-robin priority.
   assert property (@(posedge clk) disable iff (rst)
      !out_ready |=> ($stable(state) && $stable(active)))
   else $error("noc_mux: lock or priority moved while out_ready was low");

endmodule

`default_nettype wire

// ==== verilog/noc_switch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module noc_switch
   import noc_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst,

   // Input channels.
   input  flit_t [`NOC_CHANNELS-1:0] in_flit,
   input  chan_vec_t                in_last,
   input  chan_vec_t                in_valid,
   output chan_vec_t                in_ready,

   // Output ports.
   output flit_t [`NOC_OUTPUTS-1:0]  out_flit,
   output out_vec_t                 out_last,
   output out_vec_t                 out_valid,
   input  out_vec_t                 out_ready
);

   out_vec_t  [`NOC_CHANNELS-1:0] dec_req_valid;   // Decoder view, indexed by channel.
   out_vec_t  [`NOC_CHANNELS-1:0] dec_grant_ready;
   chan_vec_t [`NOC_OUTPUTS-1:0]  mux_in_valid;    // Mux view, indexed by output.
   chan_vec_t [`NOC_OUTPUTS-1:0]  mux_in_ready;

   // ========================================
   // Route decoders
   // ========================================

   for (genvar c = 0; c < `NOC_CHANNELS; c++) begin : g_dec
      noc_route_decode u_dec (
         .clk         (clk),
         .rst         (rst),
         .flit        (in_flit[c]),
         .last        (in_last[c]),
         .valid       (in_valid[c]),
         .ready       (in_ready[c]),
         .req_valid   (dec_req_valid[c]),
         .grant_ready (dec_grant_ready[c])
      );

      // Transpose the handshake between channel and output order.
      for (genvar o = 0; o < `NOC_OUTPUTS; o++) begin : g_xp
         assign mux_in_valid[o][c]    = dec_req_valid[c][o];
         assign dec_grant_ready[c][o] = mux_in_ready[o][c];
      end
   end

   // ========================================
   // Output muxes
   // ========================================

   for (genvar o = 0; o < `NOC_OUTPUTS; o++) begin : g_mux
      noc_mux u_mux (
         .clk       (clk),
         .rst       (rst),
         .in_flit   (in_flit),                     // Every mux sees every flit.
         .in_last   (in_last),
         .in_valid  (mux_in_valid[o]),
         .in_ready  (mux_in_ready[o]),
         .out_flit  (out_flit[o]),
         .out_last  (out_last[o]),
         .out_valid (out_valid[o]),
         .out_ready (out_ready[o])
      );
   end

endmodule

`default_nettype wire

// ==== testbench/tb_noc_switch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module tb_noc_switch
   import noc_pkg::*;
();

   localparam int max_cycles = 2000;               // Limit of the whole run in clock cycles.

   logic                      clk;
   logic                      rst;
   flit_t [`NOC_CHANNELS-1:0] in_flit;
   chan_vec_t                 in_last;
   chan_vec_t                 in_valid;
   chan_vec_t                 in_ready;
   flit_t [`NOC_OUTPUTS-1:0]  out_flit;
   out_vec_t                  out_last;
   out_vec_t                  out_valid;
   out_vec_t                  out_ready = '1;      // Sinks start ready.

   logic [15:0] lfsr = 16'd34;                     // Seed of the sink ready pattern.
   logic        random_ready;                      // Sinks follow the LFSR when set.
   int          route [`NOC_CHANNELS];             // Output each source is sending to.
   int          sent [`NOC_OUTPUTS];               // Flits accepted at the inputs.
   int          cycles = 0;
   int          test_errors = 0;                   // Failures found by the test tasks.
   int          mon_errors = 0;                    // Failures found by the scoreboards.

   // Scoreboard state with one set per output.
   logic open_worm [`NOC_OUTPUTS];                 // A worm is in flight.
   int   worm_src [`NOC_OUTPUTS];
   int   worm_id [`NOC_OUTPUTS];
   int   worm_len [`NOC_OUTPUTS];
   int   next_idx [`NOC_OUTPUTS];                  // Index of the next expected flit.
   int   next_id [`NOC_OUTPUTS][4];                // Next worm number per source.
   int   recv [`NOC_OUTPUTS];
   int   grant_log [`NOC_OUTPUTS][$];              // Source of every header, in order.

   noc_switch uut (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (in_flit),
      .in_last   (in_last),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_flit  (out_flit),
      .out_last  (out_last),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;                       // 4 ns period.
   end

   // ========================================
   // Stimulus helpers
   // ========================================

   // The flit carries dest, source, worm number, length and index, then a payload.
   function automatic flit_t make_flit(input int dest, input int src, input int id,
                                       input int idx, input int len);
      logic [15:0] payload;
      payload = 16'(id * 517 + idx * 49 + src * 7) ^ 16'hc35a;
      return {1'(dest), 2'(src), 5'(id), 4'(len), 4'(idx), payload};
   endfunction

   // Fibonacci LFSR with taps 16, 14, 13 and 11.
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   always @(negedge clk) begin
      if (random_ready) begin
         for (int o = 0; o < `NOC_OUTPUTS; o++) begin
            lfsr = lfsr_next(lfsr);                // One step for each ready bit.
            out_ready[o] = lfsr[0];
         end
      end else begin
         out_ready = '1;
      end
   end

   // Offers one worm and holds each flit until the switch takes it.
   task automatic send_worm(input int c, input int o, input int id, input int len);
      for (int i = 0; i < len; i++) begin
         @(negedge clk);
         route[c] = o;
         in_flit[c] = make_flit(o, c, id, i, len);
         in_last[c] = (i == len - 1);              // Last flag on the final flit.
         in_valid[c] = 1'b1;
         @(posedge clk);
         while (!in_ready[c]) @(posedge clk);
         sent[o]++;
      end
   endtask

   // Back-to-back worms from one source, then the source goes quiet.
   task automatic stream_worms(input int c, input int o, input int count, input int len);
      for (int k = 0; k < count; k++) begin
         send_worm(c, o, k, len);
      end
      @(negedge clk);
      in_valid[c] = 1'b0;
      in_last[c] = 1'b0;
   endtask

   task automatic apply_reset();
      @(negedge clk);
      rst = 1'b1;
      random_ready = 1'b0;
      in_valid = '0;
      in_last = '0;
      for (int o = 0; o < `NOC_OUTPUTS; o++) sent[o] = 0;
      repeat (3) @(posedge clk);                   // Reset spans three cycles.
      @(negedge clk);
      rst = 1'b0;
      @(posedge clk);
      if (in_ready !== '0 || out_valid !== '0) begin
         $display("ERR in_ready/out_valid after reset: %h/%h, expected 0/0", in_ready, out_valid);
         test_errors++;
      end
   endtask

   // Every flit sent must have been seen once, and no worm may be left open.
   task automatic compare_counts(input int exp0, input int exp1);
      int expected [`NOC_OUTPUTS];
      expected[0] = exp0;
      expected[1] = exp1;
      @(negedge clk);
      for (int o = 0; o < `NOC_OUTPUTS; o++) begin
         if (recv[o] != expected[o] || sent[o] != expected[o]) begin
            $display("ERR output %0d flit count: sent %h, received %h, expected %h",
                     o, sent[o], recv[o], expected[o]);
            test_errors++;
         end
         if (open_worm[o]) begin
            $display("Output %0d still has an unfinished worm at the end of a test.", o);
            test_errors++;
         end
      end
   endtask

   // ========================================
   // Scoreboards
   // ========================================

   task automatic score_flit(input int o);
      flit_t f;
      flit_t exp;
      logic  exp_last;
      int    src;
      int    id;
      f = out_flit[o];
      if (!open_worm[o]) begin                     // A header opens a new worm.
         src = int'(f[30:29]);
         id = int'(f[28:24]);
         if (f[19:16] != 4'd0) begin
            $display("Output %0d: a worm from channel %0d began without its header.", o, src);
            mon_errors++;
         end
         if (id != next_id[o][src]) begin
            $display("ERR output %0d worm number: got %h, expected %h", o, id, next_id[o][src]);
            mon_errors++;
         end
         open_worm[o] = 1'b1;
         worm_src[o] = src;
         worm_id[o] = id;
         worm_len[o] = int'(f[23:20]);
         next_idx[o] = 0;
         next_id[o][src] = id + 1;
         grant_log[o].push_back(src);
      end
      exp = make_flit(o, worm_src[o], worm_id[o], next_idx[o], worm_len[o]);
      exp_last = (next_idx[o] == worm_len[o] - 1);
      if (f !== exp) begin                         // Catches order and interleaving.
         $display("ERR out_flit[%0d]: got %h, expected %h", o, f, exp);
         mon_errors++;
      end
      if (out_last[o] !== exp_last) begin
         $display("ERR out_last[%0d]: got %h, expected %h", o, out_last[o], exp_last);
         mon_errors++;
      end
      recv[o]++;
      next_idx[o]++;
      if (next_idx[o] >= worm_len[o]) open_worm[o] = 1'b0;
   endtask

   always @(posedge clk) begin
      if (rst) begin
         for (int o = 0; o < `NOC_OUTPUTS; o++) begin
            open_worm[o] = 1'b0;
            recv[o] = 0;
            grant_log[o].delete();
            for (int s = 0; s < 4; s++) next_id[o][s] = 0;
         end
      end else begin
         for (int o = 0; o < `NOC_OUTPUTS; o++) begin
            if (out_valid[o] && out_ready[o]) score_flit(o);
         end
         for (int c = 0; c < `NOC_CHANNELS; c++) begin
            if (in_ready[c] && !(in_valid[c] && out_ready[route[c]])) begin
               $display("Channel %0d was made ready while its sink was stalled.", c);
               mon_errors++;
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= max_cycles) begin
         $display("Timeout: the run did not end within %0d cycles.", max_cycles);
         $display("Test failures found");
         $finish;
      end
   end

   // ========================================
   // Directed tests
   // ========================================

   task automatic single_flit_routes();
      apply_reset();
      for (int c = 0; c < `NOC_CHANNELS; c++) begin
         for (int o = 0; o < `NOC_OUTPUTS; o++) begin
            stream_worms(c, o, 1, 1);              // One flit with last set.
         end
      end
      compare_counts(3, 3);
   endtask

   task automatic long_worm_lock();
      apply_reset();
      fork
         stream_worms(0, 1, 1, 5);
         begin
            repeat (2) @(posedge clk);             // Competitor arrives mid-worm.
            stream_worms(2, 1, 1, 3);
         end
      join
      compare_counts(0, 8);
      if (grant_log[1].size() != 2 || grant_log[1][0] != 0 || grant_log[1][1] != 2) begin
         $display("Output 1 did not serve channel 0 and then channel 2.");
         test_errors++;
      end
   endtask

   task automatic round_robin_order();
      apply_reset();
      fork
         stream_worms(0, 0, 4, 1);
         stream_worms(1, 0, 4, 1);
         stream_worms(2, 0, 4, 1);
      join
      compare_counts(12, 0);
      for (int k = 0; k < grant_log[0].size(); k++) begin
         // Channel 0 held the grant at reset, so the cycle starts at channel 1.
         if (grant_log[0][k] != (k + 1) % `NOC_CHANNELS) begin
            $display("ERR grant_log[%0d]: got %h, expected %h",
                     k, grant_log[0][k], (k + 1) % `NOC_CHANNELS);
            test_errors++;
         end
      end
   endtask

   task automatic back_pressure();
      apply_reset();
      random_ready = 1'b1;
      fork
         stream_worms(0, 0, 3, 4);
         stream_worms(1, 0, 3, 3);
         stream_worms(2, 1, 2, 5);
      join
      random_ready = 1'b0;
      compare_counts(21, 10);
   endtask

   task automatic parallel_paths();
      int start;
      apply_reset();
      @(negedge clk);
      start = cycles;
      fork
         stream_worms(0, 0, 1, 6);
         stream_worms(1, 1, 1, 6);
      join
      if (cycles - start > 8) begin                // One after the other takes 13.
         $display("Parallel worms needed %0d cycles, so one blocked the other.",
                  cycles - start);
         test_errors++;
      end
      compare_counts(6, 6);
   endtask

   initial begin
      rst = 1'b1;
      random_ready = 1'b0;
      in_flit = '0;
      in_last = '0;
      in_valid = '0;
      single_flit_routes();
      long_worm_lock();
      round_robin_order();
      back_pressure();
      parallel_paths();
      @(negedge clk);
      $display("Summary: %0d scoreboard errors, %0d test errors", mon_errors, test_errors);
      if (mon_errors == 0 && test_errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verilog
verilog/noc_pkg.sv
verilog/arb_rr.sv
verilog/noc_route_decode.sv
verilog/noc_mux.sv
verilog/noc_switch.sv
testbench/tb_noc_switch.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the NoC switch testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f verilog.f --top-module tb_noc_switch -o sim_noc_switch \
   && ./obj_dir/sim_noc_switch | tee /dev/stderr | grep -F "All tests passed!" > /dev/null \
   && echo "Simulation passed." \
   || { echo "Simulation failed."; exit 1; }
